// ==== design/if_pkg.sv ====
`default_nettype none

package if_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN     = 32;
  // mtvec base field, placed at bit 7 of a trap target
  localparam int unsigned MTVEC_W  = 25;
  // Interrupt index for vectored traps
  localparam int unsigned IRQ_ID_W = 5;

  ////////////////////////////////////////
  // Redirect sources
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_src_e;

  // Fetch word as seen by the aligner
  // half[0] is the low halfword, half[1] the high one
  typedef union packed {
    logic [XLEN-1:0]  word;
    logic [1:0][15:0] half;
  } fetch_word_u;

  ////////////////////////////////////////
  // RVC subset
  ////////////////////////////////////////

  // Quadrants
  localparam logic [1:0] C_Q1 = 2'b01;
  localparam logic [1:0] C_Q2 = 2'b10;

  // funct3 in bits 15:13
  localparam logic [2:0] F3_C_ADDI   = 3'b000;
  localparam logic [2:0] F3_C_LI     = 3'b010;
  localparam logic [2:0] F3_C_J      = 3'b101;
  // C.MV and C.ADD share funct3, bit 12 tells them apart
  localparam logic [2:0] F3_C_MV_ADD = 3'b100;

  // Base opcodes of the expanded forms
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;

endpackage

`default_nettype wire

// ==== design/if_pc_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_pc_mux import if_pkg::*; (
  // Source of the redirect
  input  pc_src_e               pc_src_i,

  // Candidate targets
  input  logic [XLEN-1:0]       boot_addr_i,
  input  logic [XLEN-1:0]       jump_target_i,
  input  logic [XLEN-1:0]       branch_target_i,
  input  logic [XLEN-1:0]       mepc_i,
  input  logic [MTVEC_W-1:0]    mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0]   irq_id_i,

  // Selected target
  output logic [XLEN-1:0]       target_o
);

  logic [XLEN-1:0] target_n;

  always_comb begin
    // Boot as fallback
    target_n = {boot_addr_i[XLEN-1:2], 2'b00};
    case (pc_src_i)
      // Boot address forced to a word
      PC_BOOT:     target_n = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target_n = jump_target_i;
      PC_BRANCH:   target_n = branch_target_i;
      // Return to the interrupted instruction
      PC_MRET:     target_n = mepc_i;
      // All exceptions share the mtvec base
      PC_TRAP_EXC: target_n = {mtvec_addr_i, 7'h00};
      // Vectored mode, base + 4 * index
      PC_TRAP_IRQ: target_n = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     target_n = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // Instructions are at least halfword aligned
  assign target_o = {target_n[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// ==== design/if_prefetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_prefetch_unit import if_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic            clk,
  input  logic            rst_n,

  // Redirect
  input  logic            pc_set_i,
  input  logic [XLEN-1:0] target_i,

  // Instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i,

  // Words towards the aligner
  output logic            word_valid_o,
  output fetch_word_u     word_o,
  output logic            word_err_o,
  output logic [XLEN-1:0] word_addr_o,
  input  logic            word_ready_i
);

  // One spare entry so a full pipe of requests never stalls the buffer
  localparam int unsigned DEPTH = MAX_OUTSTANDING + 1;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic              fetch_en_q;
  logic [XLEN-1:0]   req_addr_q;
  logic [XLEN-1:0]   rsp_addr_q;
  logic [CNT_W-1:0]  inflight_q;
  logic [CNT_W-1:0]  inflight_n;
  logic [CNT_W-1:0]  discard_q;
  logic [CNT_W-1:0]  fill_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W:0]    credit_used;
  logic              req_acc;
  logic              push;
  logic              pop;

  // Response buffer
  fetch_word_u       fifo_data [DEPTH];
  logic              fifo_err  [DEPTH];
  logic [XLEN-1:0]   fifo_addr [DEPTH];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Every request in flight and every stored word holds one credit
  assign credit_used = {1'b0, inflight_q} + {1'b0, fill_q};

  // Idle until the first redirect
  assign instr_req_o  = fetch_en_q
                        && (credit_used < (CNT_W + 1)'(DEPTH))
                        && (inflight_q < CNT_W'(MAX_OUTSTANDING));
  assign instr_addr_o = req_addr_q;
  assign req_acc      = instr_req_o && instr_gnt_i;

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // Responses owed to requests from before a redirect are dropped
  assign push = instr_rvalid_i && (discard_q == '0) && !pc_set_i;
  assign pop  = word_valid_o && word_ready_i;

  assign inflight_n = inflight_q + CNT_W'(req_acc) - CNT_W'(instr_rvalid_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q <= 1'b0;
      req_addr_q <= '0;
      rsp_addr_q <= '0;
      inflight_q <= '0;
      discard_q  <= '0;
      fill_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      inflight_q <= inflight_n;
      if (pc_set_i) begin
        fetch_en_q <= 1'b1;
        req_addr_q <= {target_i[XLEN-1:2], 2'b00};
        rsp_addr_q <= {target_i[XLEN-1:2], 2'b00};
        // Everything still on the bus is stale now
        discard_q  <= inflight_n;
        fill_q     <= '0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else begin
        if (req_acc) begin
          req_addr_q <= req_addr_q + XLEN'(4);
        end
        if (instr_rvalid_i && (discard_q != '0)) begin
          discard_q <= discard_q - 1'b1;
        end
        if (push) begin
          // Responses are in order, so the address just counts up
          rsp_addr_q <= rsp_addr_q + XLEN'(4);
          wr_ptr_q   <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        fill_q <= fill_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // Buffer storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data[wr_ptr_q].word <= instr_rdata_i;
      fifo_err[wr_ptr_q]       <= instr_err_i;
      fifo_addr[wr_ptr_q]      <= rsp_addr_q;
    end
  end

  // Head of the buffer
  assign word_valid_o = (fill_q != '0);
  assign word_o       = fifo_data[rd_ptr_q];
  assign word_err_o   = fifo_err[rd_ptr_q];
  assign word_addr_o  = fifo_addr[rd_ptr_q];

endmodule

`default_nettype wire

// ==== design/if_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_aligner import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Redirect
  input  logic            pc_set_i,
  input  logic [XLEN-1:0] target_i,

  // Words from the prefetch buffer
  input  logic            word_valid_i,
  input  fetch_word_u     word_i,
  input  logic            word_err_i,
  output logic            word_ready_o,

  // Whole instructions
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_o,
  output logic [XLEN-1:0] pc_o,
  output logic            err_o,
  input  logic            ready_i
);

  logic [XLEN-1:0] pc_q;
  logic            resid_valid_q;
  logic [15:0]     resid_q;
  logic            resid_err_q;
  logic            skip_low_q;

  logic            valid_raw;
  logic            is_32;
  logic            keep_hi;
  logic            uses_word;
  logic            drop_word;
  logic            take;

  always_comb begin
    valid_raw = 1'b0;
    instr_o   = word_i.word;
    err_o     = word_err_i;
    is_32     = 1'b0;
    keep_hi   = 1'b0;
    uses_word = 1'b0;
    drop_word = 1'b0;
    if (resid_valid_q) begin
      if (resid_q[1:0] != 2'b11) begin
        // Residue is a whole compressed instruction
        valid_raw = 1'b1;
        instr_o   = {16'h0000, resid_q};
        err_o     = resid_err_q;
      end else begin
        // Residue is the low part of a straddling instruction
        valid_raw = word_valid_i;
        instr_o   = {word_i.half[0], resid_q};
        err_o     = resid_err_q | word_err_i;
        is_32     = 1'b1;
        uses_word = 1'b1;
        keep_hi   = 1'b1;
      end
    end else if (skip_low_q) begin
      // First word after a halfword aligned redirect
      if (word_i.half[1][1:0] != 2'b11) begin
        valid_raw = word_valid_i;
        instr_o   = {16'h0000, word_i.half[1]};
        uses_word = 1'b1;
      end else begin
        // Only the start of a 32-bit one, park it as residue
        drop_word = word_valid_i;
        keep_hi   = 1'b1;
      end
    end else if (word_i.half[0][1:0] != 2'b11) begin
      // Compressed in the low half, high half stays behind
      valid_raw = word_valid_i;
      instr_o   = {16'h0000, word_i.half[0]};
      uses_word = 1'b1;
      keep_hi   = 1'b1;
    end else begin
      // Aligned 32-bit instruction
      valid_raw = word_valid_i;
      is_32     = 1'b1;
      uses_word = 1'b1;
    end
  end

  // Nothing leaves in the cycle of a redirect
  assign instr_valid_o = valid_raw && !pc_set_i;
  assign take          = instr_valid_o && ready_i;
  assign word_ready_o  = (uses_word && take) || drop_word;
  assign pc_o          = pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      resid_valid_q <= 1'b0;
      skip_low_q    <= 1'b0;
    end else if (pc_set_i) begin
      pc_q          <= {target_i[XLEN-1:1], 1'b0};
      resid_valid_q <= 1'b0;
      skip_low_q    <= target_i[1];
    end else begin
      if (take) begin
        pc_q <= pc_q + (is_32 ? XLEN'(4) : XLEN'(2));
      end
      if (word_valid_i && word_ready_o) begin
        resid_valid_q <= keep_hi;
        skip_low_q    <= 1'b0;
      end else if (take) begin
        // Compressed residue used up
        resid_valid_q <= 1'b0;
      end
    end
  end

  // Residue halfword and its error flag
  always_ff @(posedge clk) begin
    if (word_valid_i && word_ready_o && keep_hi) begin
      resid_q     <= word_i.half[1];
      resid_err_q <= word_err_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/if_compressed_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_compressed_decoder import if_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] instr_o,
  output logic            compressed_o,
  output logic            illegal_o
);

  logic [15:0] c_instr;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm_i;
  logic [20:0] imm_j;

  assign c_instr = instr_i[15:0];
  assign rd      = c_instr[11:7];
  assign rs2     = c_instr[6:2];

  // 6-bit immediate of C.ADDI and C.LI, sign extended
  assign imm_i = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};

  // C.J offset, scrambled in bits 12:2
  assign imm_j = {{10{c_instr[12]}}, c_instr[8], c_instr[10:9], c_instr[6],
                  c_instr[7], c_instr[2], c_instr[11], c_instr[5:3], 1'b0};

  // Anything not ending in 11 is a 16-bit encoding
  assign compressed_o = (c_instr[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (compressed_o) begin
      // Unsupported by default, halfword passed zero extended
      instr_o   = {16'h0000, c_instr};
      illegal_o = 1'b1;
      case (c_instr[1:0])
        C_Q1: begin
          case (c_instr[15:13])
            // addi rd, rd, imm
            F3_C_ADDI: begin
              instr_o   = {imm_i, rd, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            // addi rd, x0, imm
            F3_C_LI: begin
              instr_o   = {imm_i, 5'd0, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            // jal x0, offset
            F3_C_J: begin
              instr_o   = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], 5'd0, OPC_JAL};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end
        C_Q2: begin
          // rs2 of zero is C.JR, C.JALR or C.EBREAK, not in the subset
          if ((c_instr[15:13] == F3_C_MV_ADD) && (rs2 != 5'd0)) begin
            illegal_o = 1'b0;
            if (c_instr[12]) begin
              // add rd, rd, rs2
              instr_o = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
            end else begin
              // add rd, x0, rs2
              instr_o = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_stage import if_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Redirect control and targets
  input  logic                  pc_set_i,
  input  pc_src_e               pc_src_i,
  input  logic [XLEN-1:0]       boot_addr_i,
  input  logic [XLEN-1:0]       jump_target_i,
  input  logic [XLEN-1:0]       branch_target_i,
  input  logic [XLEN-1:0]       mepc_i,
  input  logic [MTVEC_W-1:0]    mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0]   irq_id_i,

  // Instruction bus
  output logic                  instr_req_o,
  output logic [XLEN-1:0]       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic                  instr_err_i,

  // IF/ID register
  input  logic                  id_ready_i,
  output logic                  instr_valid_o,
  output logic [XLEN-1:0]       instr_o,
  output logic [XLEN-1:0]       pc_o,
  output logic                  compressed_o,
  output logic                  illegal_c_o,
  output logic                  bus_err_o,

  // mtvec init request towards the CSRs
  output logic                  csr_mtvec_init_o
);

  logic [XLEN-1:0] target;
  logic            word_valid;
  fetch_word_u     word;
  logic            word_err;
  logic            word_ready;
  logic            al_valid;
  logic [XLEN-1:0] al_instr;
  logic [XLEN-1:0] al_pc;
  logic            al_err;
  logic [XLEN-1:0] dec_instr;
  logic            dec_compressed;
  logic            dec_illegal;

  if_pc_mux pc_mux_i (
    .pc_src_i        (pc_src_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_id_i        (irq_id_i),
    .target_o        (target)
  );

  // Boot redirect also initializes mtvec
  assign csr_mtvec_init_o = pc_set_i && (pc_src_i == PC_BOOT);

  if_prefetch_unit #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) prefetch_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .target_i       (target),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .word_valid_o   (word_valid),
    .word_o         (word),
    .word_err_o     (word_err),
    .word_addr_o    (),
    .word_ready_i   (word_ready)
  );

  if_aligner aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .target_i      (target),
    .word_valid_i  (word_valid),
    .word_i        (word),
    .word_err_i    (word_err),
    .word_ready_o  (word_ready),
    .instr_valid_o (al_valid),
    .instr_o       (al_instr),
    .pc_o          (al_pc),
    .err_o         (al_err),
    .ready_i       (id_ready_i)
  );

  if_compressed_decoder compressed_decoder_i (
    .instr_i      (al_instr),
    .instr_o      (dec_instr),
    .compressed_o (dec_compressed),
    .illegal_o    (dec_illegal)
  );

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  // Frozen while decode stalls, emptied by a redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_o <= 1'b0;
    end else if (pc_set_i) begin
      instr_valid_o <= 1'b0;
    end else if (id_ready_i) begin
      instr_valid_o <= al_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (al_valid && id_ready_i) begin
      instr_o      <= dec_instr;
      pc_o         <= al_pc;
      compressed_o <= dec_compressed;
      illegal_c_o  <= dec_illegal;
      bus_err_o    <= al_err;
    end
  end

endmodule

`default_nettype wire

// ==== verif/if_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_stage_tb import if_pkg::*; ();

  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned CLK_PERIOD      = 20;
  // Instructions checked per redirect
  localparam int unsigned N_BOOT          = 150;
  localparam int unsigned N_PHASE         = 40;
  localparam int unsigned TOTAL_INSTR     = N_BOOT + 5 * N_PHASE;
  // Generous bound per instruction under random stalls
  localparam int unsigned LIMIT_CYCLES    = TOTAL_INSTR * 20 + 100;

  // Own copy of the opcodes for the reference
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_JAL = 7'b1101111;

  logic                clk;
  logic                rst_n;
  logic                pc_set_i;
  pc_src_e             pc_src_i;
  logic [XLEN-1:0]     boot_addr_i;
  logic [XLEN-1:0]     jump_target_i;
  logic [XLEN-1:0]     branch_target_i;
  logic [XLEN-1:0]     mepc_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                instr_req_o;
  logic [XLEN-1:0]     instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic [XLEN-1:0]     instr_rdata_i;
  logic                instr_err_i;
  logic                id_ready_i;
  logic                instr_valid_o;
  logic [XLEN-1:0]     instr_o;
  logic [XLEN-1:0]     pc_o;
  logic                compressed_o;
  logic                illegal_c_o;
  logic                bus_err_o;
  logic                csr_mtvec_init_o;

  logic [31:0]         lfsr_q;
  // Entry is {err, illegal, compressed, instr, pc}
  logic [66:0]         exp_q[$];
  logic [31:0]         rsp_q[$];
  int unsigned         accepted;
  int unsigned         total_checked;
  int unsigned         n_straddle;
  int unsigned         n_illegal;
  int unsigned         n_bus_err;
  int                  pending;
  int unsigned         rsp_wait;
  logic                hold_q;
  logic [31:0]         hold_addr_q;
  logic                started;
  // High only in the cycle of a boot redirect
  logic                mtvec_init_exp;

  if_stage #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_src_i         (pc_src_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .id_ready_i       (id_ready_i),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .pc_o             (pc_o),
    .compressed_o     (compressed_o),
    .illegal_c_o      (illegal_c_o),
    .bus_err_o        (bus_err_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [7:0] take_bits(input int unsigned n);
    logic [7:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[6:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Halfword contents, hashed from the full address
  function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] x;
    logic [15:0] h;
    x = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    x = x ^ (x >> 13);
    case (x[31:29])
      3'd0:    h = {3'b000, x[12:2], 2'b01};
      3'd1:    h = {3'b010, x[12:2], 2'b01};
      3'd2:    h = {3'b101, x[12:2], 2'b01};
      3'd3:    h = {3'b100, x[12:2], 2'b10};
      // Quadrant 0 is outside the subset
      3'd6:    h = {x[15:2], 2'b00};
      3'd7:    h = {x[15:2], x[0] ? 2'b01 : 2'b10};
      // Low half of a 32-bit instruction
      default: h = {x[15:2], 2'b11};
    endcase
    return h;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {mem_half({addr[31:2], 2'b10}), mem_half({addr[31:2], 2'b00})};
  endfunction

  // One error word in every 256 bytes
  function automatic logic word_has_err(input logic [31:0] addr);
    return (addr[7:2] == 6'h15);
  endfunction

  // Returns {illegal, expanded instruction}
  function automatic logic [32:0] expand_rvc(input logic [15:0] c);
    logic [11:0] imm6;
    logic [20:0] offs;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [32:0] r;
    rd   = c[11:7];
    rs2  = c[6:2];
    imm6 = {{7{c[12]}}, c[6:2]};
    // offset[11|4|9:8|10|6|7|3:1|5] in bits 12..2
    offs = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    r    = {1'b1, 16'h0000, c};
    case ({c[15:13], c[1:0]})
      5'b000_01: r = {1'b0, imm6, rd, 3'b000, rd, OP_IMM};
      5'b010_01: r = {1'b0, imm6, 5'd0, 3'b000, rd, OP_IMM};
      5'b101_01: r = {1'b0, offs[20], offs[10:1], offs[11], offs[19:12], 5'd0, OP_JAL};
      5'b100_10: begin
        if (rs2 != 5'd0) begin
          r = {1'b0, 7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, OP_REG};
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  // Walk the expected stream from a start PC
  task automatic fill_expected(input logic [31:0] start, input int unsigned n);
    logic [31:0] pc;
    logic [15:0] lo;
    logic [32:0] dec;
    logic        err;
    pc = start;
    for (int unsigned i = 0; i < n; i++) begin
      lo = mem_half(pc);
      if (lo[1:0] != 2'b11) begin
        dec = expand_rvc(lo);
        err = word_has_err(pc);
        exp_q.push_back({err, dec[32], 1'b1, dec[31:0], pc});
        pc = pc + 32'd2;
      end else begin
        // Second half may come from the next word
        err = word_has_err(pc) | word_has_err(pc + 32'd2);
        exp_q.push_back({err, 1'b0, 1'b0, mem_half(pc + 32'd2), lo, pc});
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic redirect(input pc_src_e src, input logic [31:0] target,
                          input int unsigned n_instr);
    @(posedge clk);
    pc_set_i       <= 1'b1;
    pc_src_i       <= src;
    mtvec_init_exp <= (src == PC_BOOT);
    exp_q.delete();
    // Margin for instructions taken before the next redirect lands
    fill_expected(target, n_instr + 8);
    accepted = 0;
    started  = 1'b1;
    @(posedge clk);
    pc_set_i       <= 1'b0;
    mtvec_init_exp <= 1'b0;
    while (accepted < n_instr) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Clock, watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    stop_with_failure("Timeout: the instruction stream stopped making progress");
  end

  ////////////////////////////////////////
  // Bus memory model and decode ready
  ////////////////////////////////////////

  always @(posedge clk) begin : bus_model
    logic        acc;
    logic [31:0] a;
    if (rst_n) begin
      acc = instr_req_o && instr_gnt_i;
      // Requests granted but not yet answered
      pending = pending + int'(acc) - int'(instr_rvalid_i);
      compare(pending <= int'(MAX_OUTSTANDING), 1, "outstanding limit held");
      if (hold_q) begin
        compare(instr_req_o, 1, "instr_req_o held until grant");
        compare(instr_addr_o, hold_addr_q, "instr_addr_o held until grant");
      end
      // A redirect may move the address
      hold_q      = instr_req_o && !instr_gnt_i && !pc_set_i;
      hold_addr_q = instr_addr_o;
      instr_rvalid_i <= 1'b0;
      if (rsp_wait != 0) begin
        rsp_wait = rsp_wait - 1;
      end else if (rsp_q.size() > 0) begin
        a = rsp_q.pop_front();
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(a);
        instr_err_i    <= word_has_err(a);
        rsp_wait = take_bits(2);
      end
      if (acc) begin
        rsp_q.push_back(instr_addr_o);
      end
      instr_gnt_i <= (take_bits(2) != 0);
      id_ready_i  <= (take_bits(2) != 0);
    end
  end

  ////////////////////////////////////////
  // Output checker
  ////////////////////////////////////////

  always @(negedge clk) begin : output_check
    logic [66:0] e;
    if (rst_n) begin
      compare(csr_mtvec_init_o, mtvec_init_exp, "csr_mtvec_init_o");
      if (!started) begin
        compare(instr_req_o, 0, "instr_req_o before first redirect");
        compare(instr_valid_o, 0, "instr_valid_o before first redirect");
      end
      // Taken by decode at the next rising edge
      if (instr_valid_o && id_ready_i && !pc_set_i) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("More instructions came out than the reference walk holds");
        end else begin
          e = exp_q.pop_front();
          compare(pc_o, e[31:0], "pc_o");
          compare(instr_o, e[63:32], "instr_o");
          compare(compressed_o, e[64], "compressed_o");
          compare(illegal_c_o, e[65], "illegal_c_o");
          compare(bus_err_o, e[66], "bus_err_o");
          accepted      = accepted + 1;
          total_checked = total_checked + 1;
          if (!e[64] && e[1]) n_straddle = n_straddle + 1;
          if (e[65]) n_illegal = n_illegal + 1;
          if (e[66]) n_bus_err = n_bus_err + 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    lfsr_q        = 32'h32da_9a7a;
    accepted      = 0;
    total_checked = 0;
    n_straddle    = 0;
    n_illegal     = 0;
    n_bus_err     = 0;
    pending       = 0;
    rsp_wait      = 0;
    hold_q        = 1'b0;
    hold_addr_q   = '0;
    started       = 1'b0;
    mtvec_init_exp  <= 1'b0;
    rst_n           <= 1'b0;
    pc_set_i        <= 1'b0;
    pc_src_i        <= PC_BOOT;
    boot_addr_i     <= 32'h0000_1002;
    jump_target_i   <= 32'h0000_2346;
    branch_target_i <= 32'h0000_3012;
    mepc_i          <= 32'h0000_1237;
    mtvec_addr_i    <= 25'h40;
    irq_id_i        <= 5'd11;
    instr_gnt_i     <= 1'b0;
    instr_rvalid_i  <= 1'b0;
    instr_rdata_i   <= '0;
    instr_err_i     <= 1'b0;
    id_ready_i      <= 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Fetch must stay idle here
    repeat (5) @(posedge clk);

    // Boot address rounded down to a word
    redirect(PC_BOOT, 32'h0000_1000, N_BOOT);
    // Halfword aligned jump and branch mid stream
    redirect(PC_JUMP, 32'h0000_2346, N_PHASE);
    redirect(PC_BRANCH, 32'h0000_3012, N_PHASE);
    // Exception at mtvec base, base sits at bit 7
    redirect(PC_TRAP_EXC, {25'h40, 7'h00}, N_PHASE);
    // Vectored interrupt, base + 4 * 11
    redirect(PC_TRAP_IRQ, {25'h40, 7'h00} + 32'd44, N_PHASE);
    // mepc with bit 0 cleared
    redirect(PC_MRET, 32'h0000_1236, N_PHASE);

    if ((n_straddle > 0) && (n_illegal > 0) && (n_bus_err > 0)) begin
      $display("Checked %0d instructions", total_checked);
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("No straddling, illegal or bus error instruction was seen");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/if_pkg.sv
design/if_pc_mux.sv
design/if_prefetch_unit.sv
design/if_aligner.sv
design/if_compressed_decoder.sv
design/if_stage.sv
verif/if_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary -Wno-fatal --top-module if_stage_tb -f project.f -o if_stage_sim \
  && ./obj_dir/if_stage_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log 2>/dev/null \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
